//--- rtl/lcd_ctrl_pkg.sv
package lcd_ctrl_pkg;

    // word register map.
    localparam logic [1:0] adr_on   = 2'd0; // on bit and init trigger.
    localparam logic [1:0] adr_cmd  = 2'd1; // instruction byte, sent with rs low.
    localparam logic [1:0] adr_char = 2'd2; // data byte, sent with rs high.
    localparam logic [1:0] adr_pos  = 2'd3; // cursor position.

    // bus timing in clock cycles, counted from the edge that takes a transfer.
    localparam int unsigned lcd_seq_w = 5;
    localparam logic [1:0] lcd_setup_cycles = 2'd3;  // rs, rw and data settle before e.
    localparam logic [4:0] lcd_pulse_cycles = 5'd13; // e high time.
    localparam logic [1:0] lcd_hold_cycles  = 2'd1;  // data held after e falls.

    // The power-up sequence selects 8-bit mode with two lines, then display on, clear
    // and entry mode increment.
    localparam int unsigned init_len = 4;
    localparam logic [7:0] init_table [init_len] = '{
        8'h38,
        8'h0C,
        8'h01,
        8'h06
    };

    // the set DDRAM address instruction carries the address in its low seven bits.
    localparam logic [7:0] pos_cmd_prefix = 8'h80;

endpackage

//--- rtl/lcd_cmd_if.sv
`timescale 1ns/100ps

// One byte transfer request toward the panel side, and the busy level back.
interface lcd_cmd_if;

    logic       start; // one cycle request, only while busy is low.
    logic       rs;    // register select sampled with start.
    logic [7:0] data;  // byte sampled with start.
    logic       busy;  // high from the cycle after start until the transfer ends.

    modport requester (
        output start,
        output rs,
        output data,
        input  busy
    );

    modport executor (
        input  start,
        input  rs,
        input  data,
        output busy
    );

endinterface

//--- rtl/lcd_wb_regs.sv
`timescale 1ns/100ps

module lcd_wb_regs import lcd_ctrl_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        cyc_i,
    input  logic        stb_i,
    input  logic        we_i,
    input  logic [3:0]  sel_i,         // byte lanes are not decoded since every access is a word.
    input  logic [1:0]  adr_i,
    input  logic [31:0] dat_i,
    output logic        ack_o,
    output logic [31:0] dat_o,
    output logic        lcd_on_o,
    output logic        init_start_o,
    lcd_cmd_if.requester cmd
);

    logic        state_q;
    logic        on_q;
    logic [6:0]  pos_q;
    logic        start_q;
    logic        init_q;
    logic        cmd_rs_q;
    logic [7:0]  cmd_data_q;
    logic        access;
    logic        wr_free;
    logic [31:0] rd_data;

    assign access  = cyc_i && stb_i && !state_q; // slave idle, take the strobe.
    assign wr_free = access && we_i && !cmd.busy;

    assign ack_o        = state_q;
    assign lcd_on_o     = on_q;
    assign init_start_o = init_q;

    assign cmd.start = start_q; // high in the ack cycle of an accepted write.
    assign cmd.rs    = cmd_rs_q;
    assign cmd.data  = cmd_data_q;

    always_comb begin
        case (adr_i)
            adr_on:   rd_data = {23'h0, cmd.busy, 7'h0, on_q};
            adr_char: rd_data = {31'h0, cmd.busy};
            adr_pos:  rd_data = {25'h0, pos_q};
            default:  rd_data = 32'h0; // the command register reads as zero.
        endcase
    end

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            state_q <= 1'b0;
            on_q    <= 1'b0;
            pos_q   <= 7'h0;
            start_q <= 1'b0;
            init_q  <= 1'b0;
        end else begin
            state_q <= access; // back to idle right after the ack.
            start_q <= 1'b0;
            init_q  <= 1'b0;
            if (access && we_i) begin
                case (adr_i)
                    adr_on: begin
                        on_q   <= dat_i[0];
                        init_q <= dat_i[1] && wr_free;
                    end
                    adr_pos: begin
                        if (wr_free) begin
                            pos_q   <= dat_i[6:0];
                            start_q <= 1'b1;
                        end
                    end
                    default: start_q <= wr_free; // dropped while a transfer runs.
                endcase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (access) begin
            dat_o <= rd_data;
        end
        if (wr_free) begin
            cmd_rs_q <= (adr_i == adr_char);
            if (adr_i == adr_pos) begin
                cmd_data_q <= pos_cmd_prefix | {1'b0, dat_i[6:0]};
            end else begin
                cmd_data_q <= dat_i[7:0];
            end
        end
    end

    start_when_free: assert property (
        @(posedge clk_i) disable iff (rst_i) cmd.start |-> !cmd.busy
    ) else $error("transfer requested while the command interface is busy.");

endmodule

//--- rtl/lcd_init_seq.sv
`timescale 1ns/100ps

module lcd_init_seq import lcd_ctrl_pkg::*; (
    input  logic clk_i,
    input  logic rst_i,
    input  logic init_start_i,
    lcd_cmd_if.executor  up,
    lcd_cmd_if.requester down
);

    logic                      active_q;
    logic [$clog2(init_len):0] idx_q;
    logic                      more;

    assign more = idx_q != ($clog2(init_len) + 1)'(init_len); // entries left to issue.

    // register requests pass straight through unless the table is playing.
    always_comb begin
        if (active_q) begin
            down.start = more && !down.busy;
            down.rs    = 1'b0;
            down.data  = init_table[idx_q[$clog2(init_len)-1:0]];
        end else begin
            down.start = up.start;
            down.rs    = up.rs;
            down.data  = up.data;
        end
    end

    assign up.busy = active_q || down.busy;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            active_q <= 1'b0;
            idx_q    <= '0;
        end else if (!active_q) begin
            if (init_start_i && !down.busy) begin
                active_q <= 1'b1;
                idx_q    <= '0;
            end
        end else if (down.start) begin
            idx_q <= idx_q + 1'b1;
        end else if (!more && !down.busy) begin
            active_q <= 1'b0; // last transfer has ended.
        end
    end

    // the strobe engine only counts one transfer, an overlapping start would be lost.
    no_start_when_busy: assert property (
        @(posedge clk_i) disable iff (rst_i) down.start |-> !down.busy
    ) else $error("transfer started while the strobe engine is busy.");

endmodule

//--- rtl/lcd_strobe_seq.sv
`timescale 1ns/100ps

module lcd_strobe_seq import lcd_ctrl_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,
    lcd_cmd_if.executor cmd,
    output logic       lcd_e_o,
    output logic       lcd_rs_o,
    output logic       lcd_rw_o,
    output logic [7:0] lcd_data_o
);

    logic [lcd_seq_w-1:0] seq_q;
    logic                 busy_q;
    logic [lcd_seq_w-1:0] e_rise_at;
    logic [lcd_seq_w-1:0] e_fall_at;
    logic [lcd_seq_w-1:0] end_at;

    // seq_q is zero on the first busy cycle, so each mark is one below its count.
    assign e_rise_at = lcd_seq_w'(lcd_setup_cycles) - 1'b1;
    assign e_fall_at = e_rise_at + lcd_pulse_cycles;
    assign end_at    = e_fall_at + lcd_seq_w'(lcd_hold_cycles);

    assign cmd.busy = busy_q;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            busy_q     <= 1'b0;
            seq_q      <= '0;
            lcd_e_o    <= 1'b0;
            lcd_rs_o   <= 1'b1;
            lcd_rw_o   <= 1'b1;
            lcd_data_o <= 8'h00;
        end else if (busy_q) begin
            seq_q <= seq_q + 1'b1;
            if (seq_q == e_rise_at) begin
                lcd_e_o <= 1'b1;
            end
            if (seq_q == e_fall_at) begin
                lcd_e_o <= 1'b0;
            end
            if (seq_q == end_at) begin
                seq_q    <= '0;
                lcd_rw_o <= 1'b1; // bus released, ready for the next byte.
                busy_q   <= 1'b0;
            end
        end else if (cmd.start) begin
            busy_q     <= 1'b1;
            seq_q      <= '0;
            lcd_rs_o   <= cmd.rs;
            lcd_rw_o   <= 1'b0; // writes only.
            lcd_data_o <= cmd.data;
        end
    end

    e_only_in_write: assert property (
        @(posedge clk_i) disable iff (rst_i) lcd_e_o |-> !lcd_rw_o
    ) else $error("e high while rw is high.");

endmodule

//--- rtl/lcd_top.sv
`timescale 1ns/100ps

module lcd_top (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        cyc_i,
    input  logic        stb_i,
    input  logic        we_i,
    input  logic [3:0]  sel_i,
    input  logic [1:0]  adr_i,
    input  logic [31:0] dat_i,
    output logic        ack_o,
    output logic [31:0] dat_o,
    output logic        lcd_e_o,
    output logic        lcd_rs_o,
    output logic        lcd_rw_o,
    output logic [7:0]  lcd_data_o,
    output logic        lcd_on_o
);

    logic init_start;

    lcd_cmd_if reg_cmd ();
    lcd_cmd_if seq_cmd ();

    lcd_wb_regs u_wb_regs (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .cyc_i        (cyc_i),
        .stb_i        (stb_i),
        .we_i         (we_i),
        .sel_i        (sel_i),
        .adr_i        (adr_i),
        .dat_i        (dat_i),
        .ack_o        (ack_o),
        .dat_o        (dat_o),
        .lcd_on_o     (lcd_on_o),
        .init_start_o (init_start),
        .cmd          (reg_cmd.requester)
    );

    lcd_init_seq u_init_seq (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .init_start_i (init_start),
        .up           (reg_cmd.executor),
        .down         (seq_cmd.requester)
    );

    lcd_strobe_seq u_strobe_seq (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .cmd        (seq_cmd.executor),
        .lcd_e_o    (lcd_e_o),
        .lcd_rs_o   (lcd_rs_o),
        .lcd_rw_o   (lcd_rw_o),
        .lcd_data_o (lcd_data_o)
    );

endmodule

//--- verification/lcd_tb.sv
`timescale 1ns/100ps

module lcd_tb import lcd_ctrl_pkg::*; ();

    logic        clk_i;
    logic        rst_i;
    logic        cyc_i;
    logic        stb_i;
    logic        we_i;
    logic [3:0]  sel_i;
    logic [1:0]  adr_i;
    logic [31:0] dat_i;
    logic        ack_o;
    logic [31:0] dat_o;
    logic        lcd_e_o;
    logic        lcd_rs_o;
    logic        lcd_rw_o;
    logic [7:0]  lcd_data_o;
    logic        lcd_on_o;

    logic [31:0] lfsr_q;
    logic [8:0]  exp_q[$];    // rs and data of each pulse still to come.
    int          exp_cnt;
    int          pulse_cnt;
    logic        e_q;
    logic        cap_rs;
    logic [7:0]  cap_data;
    logic [4:0]  cap_len;
    logic        chk_now;     // one cycle after e falls.
    logic        chk_found;
    logic [8:0]  chk_exp;

    lcd_top dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got == exp)
        else stop_run($sformatf("Error: %s got %h expected %h", name, got, exp));
    endtask

    // galois lfsr that steps once for every bit handed out.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_q[0]};
            lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? 32'h8020_0003 : 32'h0);
        end
        return r;
    endfunction

    task automatic expect_pulse(input logic rs, input logic [7:0] data);
        exp_q.push_back({rs, data});
        exp_cnt++;
    endtask

    task automatic wait_ack();
        int n;
        n = 0;
        do begin
            @(posedge clk_i);
            #2;
            n++;
        end while (!ack_o && n < 10);
        if (!ack_o) stop_run("no Wishbone acknowledge within 10 cycles.");
    endtask

    task automatic write_reg(input logic [1:0] adr, input logic [31:0] data);
        cyc_i = 1'b1;
        stb_i = 1'b1;
        we_i  = 1'b1;
        adr_i = adr;
        dat_i = data;
        wait_ack();
        cyc_i = 1'b0;
        stb_i = 1'b0;
    endtask

    task automatic read_reg(input logic [1:0] adr, output logic [31:0] data);
        cyc_i = 1'b1;
        stb_i = 1'b1;
        we_i  = 1'b0;
        adr_i = adr;
        wait_ack();
        data  = dat_o;
        cyc_i = 1'b0;
        stb_i = 1'b0;
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        int n;
        n = 0;
        do begin
            read_reg(adr_char, st);
            n++;
        end while (st[0] && n < 100);
        if (st[0]) stop_run("busy did not clear within 100 status reads.");
    endtask

    // the pulse monitor records rs, data and length of every e pulse.
    always @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            e_q       <= 1'b0;
            cap_rs    <= 1'b0;
            cap_data  <= 8'h00;
            cap_len   <= 5'd0;
            chk_now   <= 1'b0;
            chk_found <= 1'b0;
            chk_exp   <= 9'h0;
            pulse_cnt <= 0;
        end else begin
            e_q     <= lcd_e_o;
            chk_now <= 1'b0;
            if (lcd_e_o && !e_q) begin
                cap_rs   <= lcd_rs_o;
                cap_data <= lcd_data_o;
                cap_len  <= 5'd1;
            end else if (lcd_e_o) begin
                cap_len <= cap_len + 5'd1;
            end
            if (e_q && !lcd_e_o) begin
                chk_now   <= 1'b1;
                pulse_cnt <= pulse_cnt + 1;
                chk_found <= exp_q.size() != 0;
                if (exp_q.size() != 0) chk_exp <= exp_q.pop_front();
            end
        end
    end

    pulse_expected: assert property (@(posedge clk_i) disable iff (rst_i) chk_now |-> chk_found)
    else stop_run("an e pulse appeared that no register write asked for.");

    pulse_length: assert property (
        @(posedge clk_i) disable iff (rst_i) chk_now |-> cap_len == lcd_pulse_cycles
    ) else stop_run($sformatf("Error: e pulse length got %h expected %h", cap_len,
                              lcd_pulse_cycles));

    pulse_data: assert property (
        @(posedge clk_i) disable iff (rst_i) chk_now && chk_found |-> cap_data == chk_exp[7:0]
    ) else stop_run($sformatf("Error: lcd_data_o got %h expected %h", cap_data, chk_exp[7:0]));

    pulse_rs: assert property (
        @(posedge clk_i) disable iff (rst_i) chk_now && chk_found |-> cap_rs == chk_exp[8]
    ) else stop_run($sformatf("Error: lcd_rs_o got %h expected %h", cap_rs, chk_exp[8]));

    data_stable: assert property (
        @(posedge clk_i) disable iff (rst_i)
        e_q && lcd_e_o |-> lcd_data_o == cap_data && lcd_rs_o == cap_rs
    ) else stop_run($sformatf(
        "Error: lcd_rs_o and lcd_data_o got %h expected %h while e is high",
        {lcd_rs_o, lcd_data_o}, {cap_rs, cap_data}));

    rw_low: assert property (@(posedge clk_i) disable iff (rst_i) lcd_e_o |-> !lcd_rw_o)
    else stop_run($sformatf("Error: lcd_rw_o got %h expected %h", lcd_rw_o, 1'b0));

    initial begin
        logic [31:0] rd;
        logic [7:0]  b;
        logic [6:0]  pos;
        rst_i   = 1'b1;
        cyc_i   = 1'b0;
        stb_i   = 1'b0;
        we_i    = 1'b0;
        sel_i   = 4'hf;
        adr_i   = 2'd0;
        dat_i   = 32'h0;
        lfsr_q  = 32'h008d_cf77;
        exp_cnt = 0;
        repeat (8) @(posedge clk_i);
        #2;
        rst_i = 1'b0;
        check_value("ack_o", ack_o, 32'h0);
        check_value("lcd_e_o", lcd_e_o, 32'h0);
        check_value("lcd_on_o", lcd_on_o, 32'h0);
        check_value("lcd_rw_o", lcd_rw_o, 32'h1);
        read_reg(adr_char, rd);
        check_value("dat_o", rd, 32'h0);

        write_reg(adr_on, 32'h1);
        check_value("lcd_on_o", lcd_on_o, 32'h1);
        read_reg(adr_on, rd);
        check_value("dat_o", rd, 32'h1);
        write_reg(adr_on, 32'h0);
        check_value("lcd_on_o", lcd_on_o, 32'h0);
        read_reg(adr_on, rd);
        check_value("dat_o", rd, 32'h0);

        for (int k = 0; k < 2; k++) begin
            for (int i = 0; i < 10; i++) begin
                b = 8'(rand_bits(8));
                expect_pulse(k == 1, b);
                write_reg(k == 1 ? adr_char : adr_cmd, {24'h0, b});
                read_reg(adr_char, rd);
                check_value("dat_o", rd, 32'h1); // transfer running.
                wait_idle();
                check_value("pulse_cnt", pulse_cnt, exp_cnt);
            end
        end

        pos = 7'(rand_bits(7));
        expect_pulse(1'b0, 8'h80 | {1'b0, pos});
        write_reg(adr_pos, {25'h0, pos});
        wait_idle();
        check_value("pulse_cnt", pulse_cnt, exp_cnt);
        read_reg(adr_pos, rd);
        check_value("dat_o", rd, {25'h0, pos});

        // both later writes land while the first transfer is still running.
        b = 8'(rand_bits(8));
        expect_pulse(1'b0, b);
        write_reg(adr_cmd, {24'h0, b});
        write_reg(adr_cmd, {24'h0, ~b});
        write_reg(adr_pos, {25'h0, ~pos});
        wait_idle();
        check_value("pulse_cnt", pulse_cnt, exp_cnt);
        read_reg(adr_pos, rd);
        check_value("dat_o", rd, {25'h0, pos});

        for (int i = 0; i < init_len; i++) begin
            expect_pulse(1'b0, init_table[i]);
        end
        write_reg(adr_on, 32'h3);
        read_reg(adr_on, rd);
        check_value("dat_o", rd, 32'h101);
        wait_idle();
        check_value("pulse_cnt", pulse_cnt, exp_cnt); // all four ended before busy fell.
        check_value("lcd_on_o", lcd_on_o, 32'h1);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- project.f
rtl/lcd_ctrl_pkg.sv
rtl/lcd_cmd_if.sv
rtl/lcd_wb_regs.sv
rtl/lcd_init_seq.sv
rtl/lcd_strobe_seq.sv
rtl/lcd_top.sv
verification/lcd_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; the exit status carries pass or fail.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module lcd_tb -f project.f -o lcd_sim \
    && ./obj_dir/lcd_sim \
    || { echo "simulation failed"; exit 1; }
